//--- common/biu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus side of the fetch path, fixed 32-bit XLEN with 16-bit parcels
// pprot follows the APB bit order, privileged in bit 0
////////////////////////////////////////////////////////////////////////////

package biu_pkg;

  localparam int XLEN        = 32;
  localparam int PARCEL_SIZE = 16;
  localparam int PARCELS     = XLEN / PARCEL_SIZE;  // parcels per bus word
  localparam int TAG_W       = 1;                   // offset bit 1 of the fetch pc
  localparam int QUEUE_DEPTH = 2;                   // requests held by the bridge

  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } biu_size_t;

  typedef enum logic [1:0] {
    SINGLE = 2'b00,
    INCR   = 2'b01
  } biu_type_t;

  // pprot[2] instruction, pprot[1] nonsecure, pprot[0] privileged
  typedef struct packed {
    logic instr;
    logic nonsec;
    logic priv;
  } biu_prot_t;

  typedef struct packed {
    logic [XLEN-1:0]  adr;
    logic [TAG_W-1:0] tag;     // returned unchanged with the response
    biu_size_t        size;
    biu_type_t        btype;   // burst type
    biu_prot_t        prot;
    logic             we;
    logic             lock;
  } biu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]  q;       // read data
    logic [XLEN-1:0]  adr;
    logic [TAG_W-1:0] tag;
    logic             err;     // slave error
  } biu_rsp_t;

endpackage

//--- common/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// fetch side types, the parcel word is passed through undecoded
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // first fetch address after reset
  localparam logic [biu_pkg::XLEN-1:0] RESET_PC = 32'h0000_0200;

  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_t;

  typedef struct packed {
    logic [biu_pkg::XLEN-1:0]    pc;          // pc of the first valid parcel
    logic [biu_pkg::XLEN-1:0]    word;        // fetched bus word
    logic [biu_pkg::PARCELS-1:0] valid;       // one bit per parcel
    logic                        misaligned;
    logic                        error;       // bus error on this word
  } fetch_parcel_t;

endpackage

//--- hdl/fetch_pc_gen.sv
////////////////////////////////////////////////////////////////////////////
// fetch address generator, a flush wins over an acknowledge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic [biu_pkg::XLEN-1:0]  flush_pc_i,
  input  logic                      if_ack_i,
  output logic [biu_pkg::XLEN-1:0]  if_nxt_pc_o,
  output logic                      if_req_o
);

  logic running;  // set once the first clock after reset has passed

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      running <= 1'b0;
    end
    else
    begin
      running <= 1'b1;
    end
  end

  // fetch address register
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_nxt_pc_o <= fetch_pkg::RESET_PC;
    end
    else if (flush_i)
    begin
      if_nxt_pc_o <= flush_pc_i;                      // redirect target, may be unaligned
    end
    else if (if_ack_i)
    begin
      if_nxt_pc_o <= {if_nxt_pc_o[biu_pkg::XLEN-1:2] + 1'b1, 2'b00};  // next aligned word
    end
  end

  // no request while the redirect target is being loaded
  assign if_req_o = running & ~flush_i;

endmodule

//--- fetch_noicache/fetch_noicache.sv
////////////////////////////////////////////////////////////////////////////
// uncached fetch, responses must return in request order
// responses outstanding at a flush are dropped by count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_noicache #(
  parameter bit HAS_RVC = 1'b1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // pc generator side
  input  logic [biu_pkg::XLEN-1:0]  if_nxt_pc_i,
  input  logic                      if_req_i,
  output logic                      if_ack_o,
  input  logic                      if_flush_i,
  input  logic                      fetch_en_i,
  input  fetch_pkg::prv_t           prv_i,
  output fetch_pkg::fetch_parcel_t  parcel_o,
  // bus side
  output logic                      biu_stb_o,
  input  logic                      biu_stb_ack_i,
  output biu_pkg::biu_req_t         biu_req_o,
  input  logic                      biu_ack_i,
  input  biu_pkg::biu_rsp_t         biu_rsp_i
);

  // queue entries plus the registered response stage
  localparam int CNT_W = $clog2(biu_pkg::QUEUE_DEPTH) + 1;

  logic             if_flush_dly;
  logic [CNT_W-1:0] inflight;   // accepted, not yet acknowledged
  logic [CNT_W-1:0] discard;    // stale responses still to drop
  logic             req_taken;
  logic             rsp_keep;

  ////////////////////////////////////////////////////////////////////////////
  // in-flight bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  assign req_taken = biu_stb_o & biu_stb_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_flush_dly <= 1'b0;
      inflight     <= '0;
      discard      <= '0;
    end
    else
    begin
      if_flush_dly <= if_flush_i;
      case ({req_taken, biu_ack_i})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;        // none or both
      endcase
      if (if_flush_i)
      begin
        // a response arriving in the flush cycle is already gone
        discard <= biu_ack_i ? inflight - 1'b1 : inflight;
      end
      else if (biu_ack_i && discard != '0)
      begin
        discard <= discard - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign biu_stb_o = fetch_en_i & ~if_flush_i & if_req_i;
  assign if_ack_o  = req_taken;                       // advance the pc

  always_comb
  begin
    biu_req_o             = '0;
    // bit 1 travels in the tag, bit 0 is kept to flag an odd target
    biu_req_o.adr         = {if_nxt_pc_i[biu_pkg::XLEN-1:2], 1'b0, if_nxt_pc_i[0]};
    biu_req_o.tag         = if_nxt_pc_i[1 +: biu_pkg::TAG_W];
    biu_req_o.size        = biu_pkg::WORD;
    biu_req_o.btype       = biu_pkg::INCR;
    biu_req_o.prot.instr  = 1'b1;
    biu_req_o.prot.nonsec = 1'b0;
    biu_req_o.prot.priv   = (prv_i != fetch_pkg::PRV_U);
    biu_req_o.we          = 1'b0;                     // fetch never writes
    biu_req_o.lock        = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // parcel status
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_keep = biu_ack_i & fetch_en_i & ~(if_flush_i | if_flush_dly) & (discard == '0);

  always_comb
  begin
    parcel_o.pc    = {biu_rsp_i.adr[biu_pkg::XLEN-1:2], biu_rsp_i.tag, biu_rsp_i.adr[0]};
    parcel_o.word  = biu_rsp_i.q;
    parcel_o.valid = rsp_keep ? ({biu_pkg::PARCELS{1'b1}} << biu_rsp_i.tag)
                              : {biu_pkg::PARCELS{1'b0}};
    parcel_o.misaligned = HAS_RVC ? parcel_o.pc[0] : |parcel_o.pc[1:0];
    parcel_o.error = rsp_keep & biu_rsp_i.err;
  end

endmodule

//--- biu/biu_apb_bridge.sv
////////////////////////////////////////////////////////////////////////////
// APB master for reads only, one transfer at a time, two requests queued
// paddr is always word aligned, responses return in request order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module biu_apb_bridge (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // internal strobe side
  input  logic                      biu_stb_i,
  output logic                      biu_stb_ack_o,
  input  biu_pkg::biu_req_t         biu_req_i,
  output logic                      biu_ack_o,
  output biu_pkg::biu_rsp_t         biu_rsp_o,
  // APB master
  output logic [biu_pkg::XLEN-1:0]  paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output biu_pkg::biu_prot_t        pprot_o,
  input  logic [biu_pkg::XLEN-1:0]  prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i
);

  localparam int PTR_W = $clog2(biu_pkg::QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_t;

  biu_pkg::biu_req_t queue [biu_pkg::QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;
  biu_pkg::biu_req_t head;
  apb_state_t        state;

  ////////////////////////////////////////////////////////////////////////////
  // request queue
  ////////////////////////////////////////////////////////////////////////////

  assign biu_stb_ack_o = (count != biu_pkg::QUEUE_DEPTH);
  assign push          = biu_stb_i & biu_stb_ack_o;
  assign pop           = (state == ACCESS) & pready_i;
  assign head          = queue[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      queue[wr_ptr] <= biu_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB state machine over the head entry
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state <= IDLE;
    end
    else
    begin
      case (state)
        IDLE:    if (push) state <= SETUP;  // queue is empty here, psel one cycle after push
        SETUP:   state <= ACCESS;
        ACCESS:
        begin
          if (pready_i)
          begin
            // another entry left after the pop, go straight to setup
            state <= (count > CNT_W'(1) || push) ? SETUP : IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign psel_o    = (state != IDLE);
  assign penable_o = (state == ACCESS);
  assign paddr_o   = {head.adr[biu_pkg::XLEN-1:2], 2'b00};
  assign pwrite_o  = head.we;
  assign pprot_o   = head.prot;

  ////////////////////////////////////////////////////////////////////////////
  // registered response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      biu_ack_o <= 1'b0;
    end
    else
    begin
      biu_ack_o <= pop;                 // one pulse per transfer
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop)
    begin
      biu_rsp_o.q   <= prdata_i;
      biu_rsp_o.adr <= head.adr;
      biu_rsp_o.tag <= head.tag;
      biu_rsp_o.err <= pslverr_i;
    end
  end

endmodule

//--- hdl/ifetch_top.sv
////////////////////////////////////////////////////////////////////////////
// fetch path top, pc generator to fetch block to APB bridge
// parcel_o holds a fetch while any valid bit or error is set
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ifetch_top #(
  parameter bit HAS_RVC = 1'b1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_en_i,
  input  logic                      flush_i,
  input  logic [biu_pkg::XLEN-1:0]  flush_pc_i,
  input  fetch_pkg::prv_t           prv_i,
  output fetch_pkg::fetch_parcel_t  parcel_o,
  // APB master
  output logic [biu_pkg::XLEN-1:0]  paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output biu_pkg::biu_prot_t        pprot_o,
  input  logic [biu_pkg::XLEN-1:0]  prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i
);

  logic [biu_pkg::XLEN-1:0] if_nxt_pc;   // generator to fetch block
  logic                     if_req;
  logic                     if_ack;
  logic                     biu_stb;     // fetch block to bridge
  logic                     biu_stb_ack;
  biu_pkg::biu_req_t        biu_req;
  logic                     biu_ack;
  biu_pkg::biu_rsp_t        biu_rsp;

  fetch_pc_gen u_pc_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .flush_pc_i  (flush_pc_i),
    .if_ack_i    (if_ack),
    .if_nxt_pc_o (if_nxt_pc),
    .if_req_o    (if_req)
  );

  fetch_noicache #(
    .HAS_RVC (HAS_RVC)
  ) u_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .if_nxt_pc_i   (if_nxt_pc),
    .if_req_i      (if_req),
    .if_ack_o      (if_ack),
    .if_flush_i    (flush_i),
    .fetch_en_i    (fetch_en_i),
    .prv_i         (prv_i),
    .parcel_o      (parcel_o),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_req_o     (biu_req),
    .biu_ack_i     (biu_ack),
    .biu_rsp_i     (biu_rsp)
  );

  biu_apb_bridge u_biu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .biu_stb_i     (biu_stb),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_req_i     (biu_req),
    .biu_ack_o     (biu_ack),
    .biu_rsp_o     (biu_rsp),
    .paddr_o       (paddr_o),
    .psel_o        (psel_o),
    .penable_o     (penable_o),
    .pwrite_o      (pwrite_o),
    .pprot_o       (pprot_o),
    .prdata_i      (prdata_i),
    .pready_i      (pready_i),
    .pslverr_i     (pslverr_i)
  );

endmodule

//--- sim/ifetch_assertions.sv
////////////////////////////////////////////////////////////////////////////
// APB and fetch protocol checks, bound into every ifetch_top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ifetch_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     flush_i,
  input fetch_pkg::fetch_parcel_t parcel_o,
  input logic [31:0]              paddr_o,
  input logic                     psel_o,
  input logic                     penable_o
);

  // access phase only inside a selected transfer, after its setup cycle
  penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_o |-> psel_o) else $error("penable without psel");

  penable_after_setup: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(penable_o) |-> $past(psel_o & ~penable_o)) else $error("penable without setup");

  paddr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_o && penable_o) |-> $stable(paddr_o)) else $error("paddr moved in access phase");

  no_psel_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !psel_o) else $error("psel during reset");

  no_valid_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(flush_i) |-> (parcel_o.valid == '0)) else $error("valid parcel after flush");

endmodule

bind ifetch_top ifetch_assertions u_assertions (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .flush_i   (flush_i),
  .parcel_o  (parcel_o),
  .paddr_o   (paddr_o),
  .psel_o    (psel_o),
  .penable_o (penable_o)
);

//--- sim/ifetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for ifetch_top with an APB memory model, HAS_RVC set
// memory word = address ^ 32'hA5A5_5A5A, pslverr from 32'h0000_0F00 up
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ifetch_tb;

  localparam int NROWS      = 7;
  localparam int MAX_CYCLES = 600;   // per wait for parcels

  typedef struct packed {
    logic [31:0]     pc;       // redirect target
    logic [7:0]      count;    // parcels to receive
    logic [31:0]     en_pat;   // fetch enable, lsb first, one bit per cycle
    logic            exp_err;  // any parcel of the row has error set
    fetch_pkg::prv_t prv;
  } row_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     fetch_en_i;
  logic                     flush_i;
  logic [31:0]              flush_pc_i;
  fetch_pkg::prv_t          prv_i;
  fetch_pkg::fetch_parcel_t parcel_o;
  logic [31:0]              paddr_o;
  logic                     psel_o;
  logic                     penable_o;
  logic                     pwrite_o;
  biu_pkg::biu_prot_t       pprot_o;
  logic [31:0]              prdata_i;
  logic                     pready_i;
  logic                     pslverr_i;

  row_t               rows [NROWS];
  int                 seed;
  int                 error_cnt;
  int                 rcv_cnt;        // parcels received in this row
  logic [31:0]        exp_pc;         // next pc expected on parcel_o
  logic               row_err_seen;
  logic               rsp_due;        // transfer done, response this cycle
  biu_pkg::biu_prot_t rsp_prot;
  logic [1:0]         wait_left;
  int                 access_cycles;
  int                 en_low_cnt;
  bit                 parcels_arrived;

  ifetch_top #(
    .HAS_RVC (1'b1)
  ) u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_en_i (fetch_en_i),
    .flush_i    (flush_i),
    .flush_pc_i (flush_pc_i),
    .prv_i      (prv_i),
    .parcel_o   (parcel_o),
    .paddr_o    (paddr_o),
    .psel_o     (psel_o),
    .penable_o  (penable_o),
    .pwrite_o   (pwrite_o),
    .pprot_o    (pprot_o),
    .prdata_i   (prdata_i),
    .pready_i   (pready_i),
    .pslverr_i  (pslverr_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;   // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ 32'hA5A5_5A5A;
  endfunction

  function automatic fetch_pkg::fetch_parcel_t expected_parcel(input logic [31:0] pc);
    fetch_pkg::fetch_parcel_t p;
    p.pc         = pc;
    p.word       = mem_word(pc);
    p.valid      = 2'b11 << pc[1];      // upper parcel only for a halfword target
    p.misaligned = pc[0];
    p.error      = ({pc[31:2], 2'b00} >= 32'h0000_0F00);
    return p;
  endfunction

  function automatic biu_pkg::biu_prot_t expected_prot(input fetch_pkg::prv_t prv);
    biu_pkg::biu_prot_t p;
    p.instr  = 1'b1;
    p.nonsec = 1'b0;
    p.priv   = (prv != fetch_pkg::PRV_U);
    return p;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_parcel(input fetch_pkg::fetch_parcel_t act,
                              input fetch_pkg::fetch_parcel_t exp);
    if (act.pc !== exp.pc)
    begin
      error_cnt++;
      $display("[ERROR] %0t parcel_o.pc act %h exp %h", $time, act.pc, exp.pc);
    end
    if (act.word !== exp.word)
    begin
      error_cnt++;
      $display("[ERROR] %0t parcel_o.word act %h exp %h", $time, act.word, exp.word);
    end
    if (act.valid !== exp.valid)
    begin
      error_cnt++;
      $display("[ERROR] %0t parcel_o.valid act %b exp %b", $time, act.valid, exp.valid);
    end
    if (act.misaligned !== exp.misaligned)
    begin
      error_cnt++;
      $display("[ERROR] %0t parcel_o.misaligned act %b exp %b", $time,
               act.misaligned, exp.misaligned);
    end
    if (act.error !== exp.error)
    begin
      error_cnt++;
      $display("[ERROR] %0t parcel_o.error act %b exp %b", $time, act.error, exp.error);
    end
  endtask

  task automatic check_prot(input biu_pkg::biu_prot_t act, input biu_pkg::biu_prot_t exp);
    if (act !== exp)
    begin
      error_cnt++;
      $display("[ERROR] %0t pprot_o act %b exp %b", $time, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      error_cnt++;
      $display("[ERROR] %0t %s act %b exp %b", $time, name, act, exp);
    end
  endtask

  task automatic abort_run(input string why);
    error_cnt++;
    $display("timeout: %s", why);
    $display("errors: %0d", error_cnt);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB slave, inputs change on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (!rst_ni)
    begin
      pready_i = 1'b0;
    end
    else if (psel_o && !penable_o)
    begin
      wait_left = 2'($random(seed));   // 0 to 3 wait states
      pready_i  = 1'b0;
    end
    else if (psel_o && penable_o)
    begin
      if (wait_left == 2'd0)
      begin
        pready_i  = 1'b1;
        prdata_i  = mem_word(paddr_o);
        pslverr_i = (paddr_o >= 32'h0000_0F00);
      end
      else
      begin
        wait_left = wait_left - 2'd1;
        pready_i  = 1'b0;
      end
    end
    else
    begin
      pready_i = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // monitor, samples the cycle that ends at this edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      rsp_due       = 1'b0;
      access_cycles = 0;
      en_low_cnt    = 0;
    end
    else
    begin
      if (rsp_due)
      begin
        if (parcel_o.valid != '0 || parcel_o.error)
        begin
          check_parcel(parcel_o, expected_parcel(exp_pc));
          check_prot(rsp_prot, expected_prot(prv_i));
          if (parcel_o.error) row_err_seen = 1'b1;
          exp_pc  = {exp_pc[31:2] + 30'd1, 2'b00};
          rcv_cnt = rcv_cnt + 1;
        end
        else if (!fetch_en_i)
        begin
          exp_pc = {exp_pc[31:2] + 30'd1, 2'b00};  // masked while disabled
        end
      end
      else if (parcel_o.valid != '0 || parcel_o.error)
      begin
        error_cnt++;
        $display("parcel reported at %0t without a bus response", $time);
      end
      rsp_due  = psel_o & penable_o & pready_i;
      rsp_prot = pprot_o;
      if (psel_o)
      begin
        check_bit("pwrite_o", pwrite_o, 1'b0);   // read only master
      end
      // queue drains within a few transfers once fetch enable drops
      if (psel_o && !penable_o && en_low_cnt > 8)
      begin
        error_cnt++;
        $display("APB transfer started at %0t with fetch enable low", $time);
      end
      en_low_cnt    = fetch_en_i ? 0 : en_low_cnt + 1;
      access_cycles = (psel_o && penable_o && !pready_i) ? access_cycles + 1 : 0;
      if (access_cycles > 8) abort_run("pready never seen in the APB access phase");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_parcels(input int n, output bit arrived);
    int cycles;
    cycles = 0;
    while (rcv_cnt < n && cycles < MAX_CYCLES)
    begin
      @(negedge clk_i);
      cycles++;
    end
    arrived = (rcv_cnt >= n);
  endtask

  task automatic apply_row(input int idx, output bit arrived);
    row_t r;
    r = rows[idx];
    @(negedge clk_i);
    rcv_cnt      = 0;
    row_err_seen = 1'b0;
    exp_pc       = r.pc;
    prv_i        = r.prv;
    if (idx != 0)
    begin
      flush_i    = 1'b1;             // redirect with fetches outstanding
      flush_pc_i = r.pc;
      @(negedge clk_i);
      flush_i    = 1'b0;
    end
    wait_parcels(1, arrived);
    if (arrived)
    begin
      for (int i = 0; i < 32; i++)
      begin
        @(negedge clk_i);
        fetch_en_i = r.en_pat[i];
      end
      @(negedge clk_i);
      fetch_en_i = 1'b1;
      wait_parcels(int'(r.count), arrived);
    end
    if (arrived)
    begin
      check_bit("parcel_o.error", row_err_seen, r.exp_err);
    end
  endtask

  initial
  begin
    seed       = 32'h3bb4c348;
    error_cnt  = 0;
    rcv_cnt    = 0;
    exp_pc     = fetch_pkg::RESET_PC;
    row_err_seen = 1'b0;
    rst_ni     = 1'b0;
    fetch_en_i = 1'b1;
    flush_i    = 1'b0;
    flush_pc_i = '0;
    prv_i      = fetch_pkg::PRV_M;
    prdata_i   = '0;
    pready_i   = 1'b0;
    pslverr_i  = 1'b0;
    wait_left  = '0;
    //          pc            count  enable pattern  err   privilege
    rows[0] = '{32'h0000_0200, 8'd6,  32'hFFFF_FFFF, 1'b0, fetch_pkg::PRV_M};
    rows[1] = '{32'h0000_0302, 8'd5,  32'hFFFF_FFFF, 1'b0, fetch_pkg::PRV_S};
    rows[2] = '{32'h0000_0400, 8'd4,  32'hFFFF_FFFF, 1'b0, fetch_pkg::PRV_U};
    rows[3] = '{32'h0000_0EF8, 8'd6,  32'hFFFF_FFFF, 1'b1, fetch_pkg::PRV_M};
    rows[4] = '{32'h0000_0301, 8'd4,  32'hFFFF_FFFF, 1'b0, fetch_pkg::PRV_U};
    rows[5] = '{32'h0000_0600, 8'd20, 32'h0000_FF0F, 1'b0, fetch_pkg::PRV_M};
    rows[6] = '{32'h0000_0804, 8'd8,  32'hF0F0_F0F0, 1'b0, fetch_pkg::PRV_S};
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    parcels_arrived = 1'b1;
    for (int i = 0; i < NROWS && parcels_arrived; i++)
    begin
      apply_row(i, parcels_arrived);
    end
    if (!parcels_arrived)
    begin
      error_cnt++;
      $display("timeout: expected parcels did not arrive");
    end
    else
    begin
      repeat (10) @(negedge clk_i);
    end
    $display("errors: %0d", error_cnt);
    if (error_cnt == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- ifetch.f
common/biu_pkg.sv
common/fetch_pkg.sv
hdl/fetch_pc_gen.sv
fetch_noicache/fetch_noicache.sv
biu/biu_apb_bridge.sv
hdl/ifetch_top.sv
sim/ifetch_assertions.sv
sim/ifetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f ifetch.f --top-module ifetch_tb \
  -o ifetch_sim > build.log 2>&1 \
  && ./obj_dir/ifetch_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && exit 0 || exit 1
